// File: verilog/osc_pkg.sv
// *********************************************************************
// shared sizes, register map, reset values and enums for the scope
// acquisition path; imported by every design file that needs them
// *********************************************************************

package osc_pkg;

   // adc and frame geometry
   localparam int sample_w  = 12;
   localparam int frame_len = 256;
   localparam int frame_aw  = 8;
   localparam int div_w     = 12;

   // running sum holds a full frame without overflow
   localparam int sum_w = sample_w + frame_aw;

   // register map seen on the write port
   typedef enum logic [1:0] {
      reg_level = 2'd0,
      reg_edge  = 2'd1,
      reg_div   = 2'd2,
      reg_arm   = 2'd3
   } reg_addr_e;

   typedef enum logic {
      edge_rise = 1'b0,
      edge_fall = 1'b1
   } trig_edge_e;

   // capture fsm
   typedef enum logic [1:0] {
      cap_idle  = 2'd0,
      cap_prime = 2'd1,
      cap_wait  = 2'd2,
      cap_store = 2'd3
   } cap_state_e;

   // settings after reset, mid scale level and full rate
   localparam logic [sample_w-1:0] level_default = 12'd2048;
   localparam logic [div_w-1:0]    div_default   = 12'd0;
   localparam trig_edge_e          edge_default  = edge_rise;

endpackage

// File: verilog/frame_if.sv
// *********************************************************************
// frame write stream from the trigger block to the statistics block,
// one word per stored sample plus start and done markers
// *********************************************************************

`timescale 1ns/1ps

interface frame_if;
   import osc_pkg::*;

   logic                wr_en;
   logic [frame_aw-1:0] wr_addr;
   logic [sample_w-1:0] wr_data;
   // goes with the write at address 0
   logic                frame_start;
   // one clock after the write at the last address
   logic                frame_done;

   modport source (output wr_en, wr_addr, wr_data, frame_start, frame_done);

   modport sink (input wr_en, wr_addr, wr_data, frame_start, frame_done);

endinterface

// File: verilog/osc_settings.sv
// *********************************************************************
// user settings register block; holds level, edge and sample divider
// and turns a write to the arm address into a single clock pulse
// *********************************************************************

`timescale 1ns/1ps

module osc_settings (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         reg_wr,
   input  osc_pkg::reg_addr_e           reg_addr,
   input  logic [osc_pkg::sample_w-1:0] reg_wdata,
   output logic [osc_pkg::sample_w-1:0] trigger_level,
   output osc_pkg::trig_edge_e          trigger_edge,
   output logic [osc_pkg::div_w-1:0]    sample_div,
   output logic                         arm
);
   import osc_pkg::*;

   // write to the arm address this clock
   logic arm_wr;

   assign arm_wr = reg_wr && (reg_addr == reg_arm);

   // held settings, written on the strobe edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         trigger_level <= level_default;
         trigger_edge  <= edge_default;
         sample_div    <= div_default;
      end else if (reg_wr) begin
         case (reg_addr)
            reg_level: trigger_level <= reg_wdata;
            // only bit 0 carries the edge
            reg_edge:  trigger_edge  <= trig_edge_e'(reg_wdata[0]);
            reg_div:   sample_div    <= reg_wdata[div_w-1:0];
            // arm has no stored value
            reg_arm:   ;
            default:   ;
         endcase
      end
   end

   // arm pulse on the clock after the write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arm <= 1'b0;
      end else begin
         arm <= arm_wr;
      end
   end

   // capture block relies on arm being a single clock wide
   a_arm_single: assert property (
      @(posedge clk) disable iff (!rst_n)
      arm |=> !arm
   ) else $error("arm high on two clocks in a row");

endmodule

// File: verilog/sample_clock.sv
// *********************************************************************
// sample strobe divider; ticks once every sample_div + 1 clocks,
// a new divider takes effect at the next tick
// *********************************************************************

`timescale 1ns/1ps

module sample_clock (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [osc_pkg::div_w-1:0] sample_div,
   output logic                      sample_tick
);
   import osc_pkg::*;

   // clocks left until the next tick
   logic [div_w-1:0] cnt;
   // idle clocks since the last tick, checker only
   logic [div_w-1:0] idle_run;
   // divider that set up the current gap
   logic [div_w-1:0] gap_div;

   // div 0 keeps cnt at zero, tick every clock
   assign sample_tick = (cnt == '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (sample_tick) begin
         cnt <= sample_div;
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   // independent up count to check the gap against
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idle_run <= '0;
         gap_div  <= div_default;
      end else if (sample_tick) begin
         idle_run <= '0;
         gap_div  <= sample_div;
      end else begin
         idle_run <= idle_run + 1'b1;
      end
   end

   // exactly sample_div low clocks between two ticks
   a_tick_gap: assert property (
      @(posedge clk) disable iff (!rst_n)
      sample_tick == (idle_run == gap_div)
   ) else $error("sample tick gap differs from divider");

endmodule

// File: verilog/trigger_capture.sv
// *********************************************************************
// edge trigger and frame store; once armed, waits for a level crossing
// and writes the next 256 samples, served back on a read port
// *********************************************************************

`timescale 1ns/1ps

module trigger_capture (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         sample_tick,
   input  logic [osc_pkg::sample_w-1:0] adc_data,
   input  logic [osc_pkg::sample_w-1:0] trigger_level,
   input  osc_pkg::trig_edge_e          trigger_edge,
   input  logic                         arm,
   output logic                         busy,
   input  logic [osc_pkg::frame_aw-1:0] rd_addr,
   output logic [osc_pkg::sample_w-1:0] rd_data,
   frame_if.source                      frame
);
   import osc_pkg::*;

   localparam logic [frame_aw-1:0] last_addr = frame_aw'(frame_len - 1);

   cap_state_e state;

   // sample from the tick before
   logic [sample_w-1:0] prev_sample;
   logic                rise_hit;
   logic                fall_hit;
   logic                trig_hit;
   // final word of the frame on the bus now
   logic                last_sent;

   // frame memory, one word per sample
   logic [sample_w-1:0] mem [frame_len];

   // crossing tests against the level
   assign rise_hit = (prev_sample < trigger_level) && (adc_data >= trigger_level);
   assign fall_hit = (prev_sample > trigger_level) && (adc_data <= trigger_level);
   assign trig_hit = (trigger_edge == edge_rise) ? rise_hit : fall_hit;

   assign last_sent = frame.wr_en && (frame.wr_addr == last_addr);

   // anything but idle blocks a new arm
   assign busy = (state != cap_idle);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= cap_idle;
      end else begin
         case (state)
            cap_idle: begin
               if (arm) begin
                  state <= cap_prime;
               end
            end
            // first tick only fills prev_sample
            cap_prime: begin
               if (sample_tick) begin
                  state <= cap_wait;
               end
            end
            cap_wait: begin
               if (sample_tick && trig_hit) begin
                  state <= cap_store;
               end
            end
            // leave once word 255 reaches the memory
            cap_store: begin
               if (last_sent) begin
                  state <= cap_idle;
               end
            end
            default: state <= cap_idle;
         endcase
      end
   end

   // previous sample follows every tick
   always_ff @(posedge clk) begin
      if (sample_tick) begin
         prev_sample <= adc_data;
      end
   end

   // write strobes, address and frame markers
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         frame.wr_en       <= 1'b0;
         frame.wr_addr     <= '0;
         frame.frame_start <= 1'b0;
         frame.frame_done  <= 1'b0;
      end else begin
         frame.wr_en       <= 1'b0;
         frame.frame_start <= 1'b0;
         frame.frame_done  <= last_sent;
         if (state == cap_wait && sample_tick && trig_hit) begin
            // triggering sample opens the frame
            frame.wr_en       <= 1'b1;
            frame.wr_addr     <= '0;
            frame.frame_start <= 1'b1;
         end else if (state == cap_store && sample_tick && !last_sent) begin
            frame.wr_en   <= 1'b1;
            frame.wr_addr <= frame.wr_addr + 1'b1;
         end
      end
   end

   // sample latched on its tick, qualified by wr_en
   always_ff @(posedge clk) begin
      if (sample_tick) begin
         frame.wr_data <= adc_data;
      end
   end

   // memory write and display read, rd_data one clock after rd_addr
   always_ff @(posedge clk) begin
      if (frame.wr_en) begin
         mem[frame.wr_addr] <= frame.wr_data;
      end
      rd_data <= mem[rd_addr];
   end

   a_wr_in_store: assert property (
      @(posedge clk) disable iff (!rst_n)
      frame.wr_en |-> state == cap_store
   ) else $error("frame write outside store state");

   a_done_idle: assert property (
      @(posedge clk) disable iff (!rst_n)
      frame.frame_done |-> state == cap_idle
   ) else $error("frame done while capture still running");

endmodule

// File: verilog/waveform_stats.sv
// *********************************************************************
// frame statistics; tracks min, max and sum of the write stream and
// latches them with a frame_ready pulse after frame_done
// *********************************************************************

`timescale 1ns/1ps

module waveform_stats (
   input  logic                         clk,
   input  logic                         rst_n,
   frame_if.sink                        frame,
   output logic [osc_pkg::sample_w-1:0] sample_min,
   output logic [osc_pkg::sample_w-1:0] sample_max,
   output logic [osc_pkg::sample_w-1:0] sample_avg,
   output logic                         frame_ready
);
   import osc_pkg::*;

   // running values for the frame being written
   logic [sample_w-1:0] run_min;
   logic [sample_w-1:0] run_max;
   logic [sum_w-1:0]    run_sum;

   // first word seeds, later words update
   always_ff @(posedge clk) begin
      if (frame.wr_en) begin
         if (frame.frame_start) begin
            run_min <= frame.wr_data;
            run_max <= frame.wr_data;
            run_sum <= sum_w'(frame.wr_data);
         end else begin
            if (frame.wr_data < run_min) begin
               run_min <= frame.wr_data;
            end
            if (frame.wr_data > run_max) begin
               run_max <= frame.wr_data;
            end
            run_sum <= run_sum + sum_w'(frame.wr_data);
         end
      end
   end

   // results and ready pulse, one clock after frame_done
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         frame_ready <= 1'b0;
         sample_min  <= '0;
         sample_max  <= '0;
         sample_avg  <= '0;
      end else begin
         frame_ready <= frame.frame_done;
         if (frame.frame_done) begin
            sample_min <= run_min;
            sample_max <= run_max;
            // divide by 256, drop the low address bits
            sample_avg <= run_sum[sum_w-1:frame_aw];
         end
      end
   end

   // mean of a frame lies between its extremes
   a_stats_order: assert property (
      @(posedge clk) disable iff (!rst_n)
      frame_ready |-> (sample_min <= sample_avg) && (sample_avg <= sample_max)
   ) else $error("frame statistics out of order");

endmodule

// File: verilog/osc_top.sv
// *********************************************************************
// scope acquisition top; settings, sample divider, trigger capture and
// frame statistics, with settings and results on plain ports
// *********************************************************************

`timescale 1ns/1ps

module osc_top (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [osc_pkg::sample_w-1:0] adc_data,
   input  logic                         reg_wr,
   input  osc_pkg::reg_addr_e           reg_addr,
   input  logic [osc_pkg::sample_w-1:0] reg_wdata,
   input  logic [osc_pkg::frame_aw-1:0] rd_addr,
   output logic [osc_pkg::sample_w-1:0] rd_data,
   output logic                         capture_busy,
   output logic                         frame_ready,
   output logic [osc_pkg::sample_w-1:0] sample_min,
   output logic [osc_pkg::sample_w-1:0] sample_max,
   output logic [osc_pkg::sample_w-1:0] sample_avg,
   output logic [osc_pkg::sample_w-1:0] trigger_level_out,
   output logic [osc_pkg::div_w-1:0]    sample_div_out
);
   import osc_pkg::*;

   // settings
   logic [sample_w-1:0] trigger_level;
   trig_edge_e          trigger_edge;
   logic [div_w-1:0]    sample_div;
   logic                arm;

   logic                sample_tick;

   // trigger to stats
   frame_if frame_bus ();

   // settings shown outside, no read back
   assign trigger_level_out = trigger_level;
   assign sample_div_out    = sample_div;

   osc_settings u_settings (
      .clk,
      .rst_n,
      .reg_wr,
      .reg_addr,
      .reg_wdata,
      .trigger_level,
      .trigger_edge,
      .sample_div,
      .arm
   );

   sample_clock u_sample_clock (
      .clk,
      .rst_n,
      .sample_div,
      .sample_tick
   );

   trigger_capture u_trigger_capture (
      .clk,
      .rst_n,
      .sample_tick,
      .adc_data,
      .trigger_level,
      .trigger_edge,
      .arm,
      .busy    (capture_busy),
      .rd_addr,
      .rd_data,
      .frame   (frame_bus.source)
   );

   waveform_stats u_waveform_stats (
      .clk,
      .rst_n,
      .frame   (frame_bus.sink),
      .sample_min,
      .sample_max,
      .sample_avg,
      .frame_ready
   );

endmodule

// File: verif/osc_tb.sv
// *********************************************************************
// testbench for the scope acquisition top; ramp and triangle adc model,
// register stimulus, frame read back, checked against a tick model
// *********************************************************************

`timescale 1ns/1ps

module osc_tb;
   import osc_pkg::*;

   // largest divider the lfsr can pick
   localparam int max_div = 31;
   localparam int n_tests = 6;

   logic                clk;
   logic                rst_n;
   logic [sample_w-1:0] adc_data = '0;
   logic                reg_wr;
   reg_addr_e           reg_addr;
   logic [sample_w-1:0] reg_wdata;
   logic [frame_aw-1:0] rd_addr;
   logic [sample_w-1:0] rd_data;
   logic                capture_busy;
   logic                frame_ready;
   logic [sample_w-1:0] sample_min;
   logic [sample_w-1:0] sample_max;
   logic [sample_w-1:0] sample_avg;
   logic [sample_w-1:0] trigger_level_out;
   logic [div_w-1:0]    sample_div_out;

   // adc waveform select and triangle direction
   logic wave_tri;
   logic tri_up = 1'b1;

   // tick and trigger model, fed only from the register bus and adc
   logic [div_w-1:0]    m_cnt;
   logic [div_w-1:0]    m_div;
   logic [sample_w-1:0] m_level;
   logic                m_fall;
   logic                arm_q;
   cap_state_e          phase;
   logic [sample_w-1:0] m_prev;
   // every sample taken on a predicted tick, oldest overwritten
   logic [sample_w-1:0] tick_hist [1024];
   logic [9:0]          hist_wr;
   logic [8:0]          exp_n;
   logic [sample_w-1:0] exp_frame [frame_len];
   logic [sample_w-1:0] rd_buf [frame_len];

   logic [15:0] lfsr_state;
   string       test_name;
   int          test_start_errors;
   int          errors;
   int          tests_failed;
   int          arm_writes;

   osc_top DUT (
      .clk,
      .rst_n,
      .adc_data,
      .reg_wr,
      .reg_addr,
      .reg_wdata,
      .rd_addr,
      .rd_data,
      .capture_busy,
      .frame_ready,
      .sample_min,
      .sample_max,
      .sample_avg,
      .trigger_level_out,
      .sample_div_out
   );

   always #50 clk = ~clk;

   // adc model, new value every clock
   always @(posedge clk) begin
      if (!wave_tri) begin
         adc_data <= adc_data + 12'd1;
      end else if (tri_up) begin
         if (adc_data >= 12'd4088) begin
            tri_up   <= 1'b0;
            adc_data <= adc_data - 12'd8;
         end else begin
            adc_data <= adc_data + 12'd8;
         end
      end else begin
         if (adc_data < 12'd8) begin
            tri_up   <= 1'b1;
            adc_data <= adc_data + 12'd8;
         end else begin
            adc_data <= adc_data - 12'd8;
         end
      end
   end

   // crossing rule, previous against current sample
   function automatic logic crossed(input logic fall, input logic [sample_w-1:0] prev,
                                    input logic [sample_w-1:0] cur,
                                    input logic [sample_w-1:0] lvl);
      if (fall) begin
         return (prev > lvl) && (cur <= lvl);
      end
      return (prev < lvl) && (cur >= lvl);
   endfunction

   // shadow of every sample taken on a predicted tick
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_cnt   <= '0;
         m_div   <= '0;
         m_level <= 12'd2048;
         m_fall  <= 1'b0;
         arm_q   <= 1'b0;
         phase   <= cap_idle;
         m_prev  <= '0;
         hist_wr <= '0;
         exp_n   <= '0;
      end else begin
         // arm pulse follows the write by one clock
         arm_q <= reg_wr && (reg_addr == reg_arm);
         if (reg_wr && reg_addr == reg_level) begin
            m_level <= reg_wdata;
         end
         if (reg_wr && reg_addr == reg_edge) begin
            m_fall <= reg_wdata[0];
         end
         if (reg_wr && reg_addr == reg_div) begin
            m_div <= reg_wdata;
         end
         if (arm_q && phase == cap_idle) begin
            phase <= cap_prime;
         end
         if (m_cnt == '0) begin
            m_cnt              <= m_div;
            m_prev             <= adc_data;
            tick_hist[hist_wr] <= adc_data;
            hist_wr            <= hist_wr + 10'd1;
            case (phase)
               cap_prime: phase <= cap_wait;
               cap_wait: begin
                  if (crossed(m_fall, m_prev, adc_data, m_level)) begin
                     exp_frame[0] <= adc_data;
                     exp_n        <= 9'd1;
                     phase        <= cap_store;
                  end
               end
               cap_store: begin
                  exp_frame[exp_n[7:0]] <= adc_data;
                  exp_n                 <= exp_n + 9'd1;
                  if (exp_n == 9'd255) begin
                     phase <= cap_idle;
                  end
               end
               default: ;
            endcase
         end else begin
            m_cnt <= m_cnt - 12'd1;
         end
      end
   end

   // frame_ready only after some arm write
   a_no_ready_unarmed: assert property (
      @(posedge clk) disable iff (!rst_n)
      frame_ready |-> arm_writes > 0
   ) else begin
      $display("frame_ready rose in test %s without any arm write", test_name);
      errors++;
   end

   a_ready_pulse: assert property (
      @(posedge clk) disable iff (!rst_n)
      frame_ready |=> !frame_ready
   ) else begin
      $display("frame_ready in test %s stayed high for more than one clock", test_name);
      errors++;
   end

   a_ready_idle: assert property (
      @(posedge clk) disable iff (!rst_n)
      frame_ready |-> !capture_busy
   ) else begin
      $display("capture still busy at frame_ready in test %s", test_name);
      errors++;
   end

   // 16 bit fibonacci lfsr, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one lfsr step per bit taken
   task automatic take_bits(input int n, output int val);
      int i;
      val = 0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         val = (val << 1) | int'(lfsr_state[0]);
      end
   endtask

   task automatic check_val(input string what, input int expected, input int actual);
      assert (expected == actual) else begin
         $display("Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
         errors++;
      end
   endtask

   function automatic int word_at(input int k);
      return int'(rd_buf[k[frame_aw-1:0]]);
   endfunction

   // newest run of tick samples equal to the read-back frame,
   // returns the sample on the tick before it, or -1 if none
   function automatic int tick_before_frame();
      int         q;
      int         k;
      logic [9:0] s;
      logic       same;
      for (q = 0; q < 1024 - frame_len; q++) begin
         s    = hist_wr - 10'(frame_len + q);
         same = 1'b1;
         for (k = 0; k < frame_len && same; k++) begin
            if (tick_hist[s + 10'(k)] !== rd_buf[k]) begin
               same = 1'b0;
            end
         end
         if (same) begin
            return int'(tick_hist[s - 10'd1]);
         end
      end
      return -1;
   endfunction

   task automatic write_reg(input reg_addr_e a, input logic [sample_w-1:0] d);
      if (a == reg_arm) begin
         arm_writes++;
      end
      @(posedge clk);
      reg_wr    <= 1'b1;
      reg_addr  <= a;
      reg_wdata <= d;
      @(posedge clk);
      reg_wr    <= 1'b0;
   endtask

   task automatic wait_ready();
      @(posedge clk);
      while (frame_ready !== 1'b1) begin
         @(posedge clk);
      end
   endtask

   task automatic wait_busy();
      @(posedge clk);
      while (capture_busy !== 1'b1) begin
         @(posedge clk);
      end
   endtask

   task automatic begin_test(input string name);
      test_name         = name;
      test_start_errors = errors;
   endtask

   task automatic end_test();
      if (errors == test_start_errors) begin
         $display("test %s passed", test_name);
      end else begin
         $display("test %s failed with %0d errors", test_name, errors - test_start_errors);
         tests_failed++;
      end
   endtask

   task automatic check_trigger(input int lvl, input logic fall);
      int w0;
      int pre;
      w0  = word_at(0);
      pre = tick_before_frame();
      if (pre < 0) begin
         $display("%s: read-back frame matches no run of sampled adc values", test_name);
         errors++;
      end else if (fall) begin
         assert (w0 <= lvl && pre > lvl) else begin
            $display("Error: %s falling trigger level %0d expected word 0 <= %0d after > %0d",
                     test_name, lvl, lvl, lvl);
            $display("Error: %s actual word 0 %0d after %0d", test_name, w0, pre);
            errors++;
         end
      end else begin
         assert (w0 >= lvl && pre < lvl) else begin
            $display("Error: %s rising trigger level %0d expected word 0 >= %0d after < %0d",
                     test_name, lvl, lvl, lvl);
            $display("Error: %s actual word 0 %0d after %0d", test_name, w0, pre);
            errors++;
         end
      end
   endtask

   // arm, wait for the frame, read it back and check it
   task automatic capture_and_check(input int lvl, input int dv, input logic ramp,
                                    input logic fall);
      int k;
      int j;
      int e0;
      int mn;
      int mx;
      int sum;
      write_reg(reg_arm, '0);
      wait_ready();
      // rd_data lags rd_addr by one clock
      for (k = 0; k < frame_len + 2; k++) begin
         @(posedge clk);
         j = k - 2;
         if (k >= 2) begin
            rd_buf[j[frame_aw-1:0]] = rd_data;
         end
         if (k < frame_len) begin
            rd_addr <= k[frame_aw-1:0];
         end
      end
      check_val("model word count", frame_len, int'(exp_n));
      e0 = errors;
      for (k = 0; k < frame_len && errors == e0; k++) begin
         check_val("frame word", int'(exp_frame[k[frame_aw-1:0]]), word_at(k));
      end
      // ramp step of one per clock, so d + 1 per tick
      e0 = errors;
      for (k = 0; ramp && k < frame_len - 1 && errors == e0; k++) begin
         check_val("sample step", dv + 1, (word_at(k + 1) - word_at(k)) & 4095);
      end
      check_trigger(lvl, fall);
      mn  = 4095;
      mx  = 0;
      sum = 0;
      for (k = 0; k < frame_len; k++) begin
         sum += word_at(k);
         mn = (word_at(k) < mn) ? word_at(k) : mn;
         mx = (word_at(k) > mx) ? word_at(k) : mx;
      end
      check_val("sample_min", mn, int'(sample_min));
      check_val("sample_max", mx, int'(sample_max));
      check_val("sample_avg", sum / frame_len, int'(sample_avg));
   endtask

   task automatic run_capture(input string name, input logic use_tri, input logic fall,
                              input logic rearm);
      int lvl;
      int dv;
      begin_test(name);
      // level kept clear of both ends so both waveforms cross it
      take_bits(12, lvl);
      lvl = 512 + lvl % 3072;
      take_bits(5, dv);
      @(posedge clk);
      wave_tri <= use_tri;
      write_reg(reg_level, lvl[sample_w-1:0]);
      write_reg(reg_edge, {11'd0, fall});
      write_reg(reg_div, dv[div_w-1:0]);
      @(posedge clk);
      check_val("trigger_level_out", lvl, int'(trigger_level_out));
      check_val("sample_div_out", dv, int'(sample_div_out));
      if (rearm) begin
         // second arm lands while the first capture runs
         write_reg(reg_arm, '0);
         wait_busy();
         write_reg(reg_arm, '0);
         wait_ready();
         repeat (4) @(posedge clk);
         assert (!capture_busy) else begin
            $display("%s: arm written while busy started another capture", test_name);
            errors++;
         end
      end
      capture_and_check(lvl, dv, !use_tri, fall);
      end_test();
   endtask

   initial begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      reg_wr       = 1'b0;
      reg_addr     = reg_level;
      reg_wdata    = '0;
      rd_addr      = '0;
      wave_tri     = 1'b0;
      lfsr_state   = 16'd65;
      test_name    = "reset";
      errors       = 0;
      tests_failed = 0;
      arm_writes   = 0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      begin_test("reset_defaults");
      repeat (2) @(posedge clk);
      check_val("capture_busy", 0, int'(capture_busy));
      check_val("frame_ready", 0, int'(frame_ready));
      check_val("trigger_level_out", 2048, int'(trigger_level_out));
      check_val("sample_div_out", 0, int'(sample_div_out));
      // idle stretch, no arm so no frame
      repeat (300) @(posedge clk);
      end_test();

      run_capture("ramp_rate", 1'b0, 1'b0, 1'b0);
      run_capture("rise_trigger", 1'b0, 1'b0, 1'b0);
      run_capture("fall_trigger", 1'b1, 1'b1, 1'b0);
      run_capture("stats_triangle", 1'b1, 1'b0, 1'b0);
      run_capture("rearm", 1'b0, 1'b0, 1'b1);

      $display("tests %0d, failed %0d, errors %0d", n_tests, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // every test fits in two frames at the slowest divider
   initial begin
      repeat (n_tests * frame_len * (max_div + 1) * 2) @(posedge clk);
      $display("watchdog expired, test %s did not finish", test_name);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// File: all.f
verilog/osc_pkg.sv
verilog/frame_if.sv
verilog/osc_settings.sv
verilog/sample_clock.sv
verilog/trigger_capture.sv
verilog/waveform_stats.sv
verilog/osc_top.sv
verif/osc_tb.sv

// File: Makefile
# Verilator build and run for the scope acquisition testbench

VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := osc_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := SIMULATION FAILED

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a crash or a fail line in the log both fail the run
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	   echo "run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
